// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and register file geometry
`define CORE_DATA_WIDTH 16
`define CORE_REG_COUNT 16
`define CORE_REG_SEL_WIDTH 4

// Data memory geometry
`define CORE_MEM_DEPTH 256
`define CORE_MEM_ADDR_WIDTH 8

// Registers owned by the second write port (load/store side)
`define CORE_SPECIAL_REG_A 12
`define CORE_SPECIAL_REG_B 13

`endif

// ==== design/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

	//////////////////////////////
	// Instruction encoding
	//////////////////////////////

	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_AND   = 3'd2,
		OP_XOR   = 3'd3,
		OP_MOVI  = 3'd4,
		OP_LOAD  = 3'd5,
		OP_STORE = 3'd6
	} opcode_t;

	// rs1 doubles as address base, rs2 as store data source
	typedef struct packed {
		opcode_t opcode;
		logic [`CORE_REG_SEL_WIDTH-1:0] rd;
		logic [`CORE_REG_SEL_WIDTH-1:0] rs1;
		logic [`CORE_REG_SEL_WIDTH-1:0] rs2;
		logic [7:0] imm;
	} instr_t;

	//////////////////////////////
	// Datapath transfers
	//////////////////////////////

	typedef struct packed {
		logic en;
		logic [`CORE_REG_SEL_WIDTH-1:0] sel;
		logic [`CORE_DATA_WIDTH-1:0] data;
	} reg_write_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [`CORE_MEM_ADDR_WIDTH-1:0] addr;
		logic [`CORE_DATA_WIDTH-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module register_file (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`CORE_REG_SEL_WIDTH-1:0] read_sel_1,
	input wire logic [`CORE_REG_SEL_WIDTH-1:0] read_sel_2,
	output logic [`CORE_DATA_WIDTH-1:0] read_data_1,
	output logic [`CORE_DATA_WIDTH-1:0] read_data_2,
	input wire core_pkg::reg_write_t port_1_write,
	input wire core_pkg::reg_write_t port_2_write
);

	logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_COUNT];

	logic port_1_special;
	logic port_2_special;
	logic port_1_ok;
	logic port_2_ok;

	// Ownership check per port
	assign port_1_special = (port_1_write.sel == `CORE_SPECIAL_REG_A) ||
		(port_1_write.sel == `CORE_SPECIAL_REG_B);
	assign port_2_special = (port_2_write.sel == `CORE_SPECIAL_REG_A) ||
		(port_2_write.sel == `CORE_SPECIAL_REG_B);

	// Writes to the other port's registers just vanish
	assign port_1_ok = port_1_write.en && !port_1_special;
	assign port_2_ok = port_2_write.en && port_2_special;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Targets never overlap, so both may land in one cycle
			if (port_1_ok) begin
				regs[port_1_write.sel] <= port_1_write.data;
			end
			if (port_2_ok) begin
				regs[port_2_write.sel] <= port_2_write.data;
			end
		end
	end

	//////////////////////////////
	// Combinational reads
	//////////////////////////////

	assign read_data_1 = regs[read_sel_1];
	assign read_data_2 = regs[read_sel_2];

endmodule

`default_nettype wire

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module alu_unit (
	input wire logic go,
	input wire core_pkg::opcode_t opcode,
	input wire logic [`CORE_REG_SEL_WIDTH-1:0] rd,
	input wire logic [`CORE_DATA_WIDTH-1:0] operand_a,
	input wire logic [`CORE_DATA_WIDTH-1:0] operand_b,
	input wire logic [7:0] imm,
	output core_pkg::reg_write_t alu_write
);

	logic [`CORE_DATA_WIDTH-1:0] result;
	logic writes_reg;

	always_comb begin
		result = '0;
		writes_reg = 1'b0;
		case (opcode)
			core_pkg::OP_ADD: begin
				result = operand_a + operand_b;
				writes_reg = 1'b1;
			end
			core_pkg::OP_SUB: begin
				result = operand_a - operand_b;
				writes_reg = 1'b1;
			end
			core_pkg::OP_AND: begin
				result = operand_a & operand_b;
				writes_reg = 1'b1;
			end
			core_pkg::OP_XOR: begin
				result = operand_a ^ operand_b;
				writes_reg = 1'b1;
			end
			// Immediate is zero-extended
			core_pkg::OP_MOVI: begin
				result = {{(`CORE_DATA_WIDTH-8){1'b0}}, imm};
				writes_reg = 1'b1;
			end
			default: begin
				writes_reg = 1'b0;
			end
		endcase
	end

	assign alu_write.en = go && writes_reg;
	assign alu_write.sel = rd;
	assign alu_write.data = result;

endmodule

`default_nettype wire

// ==== design/issue_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module issue_unit (
	input wire logic clk,
	input wire logic reset,
	input wire logic instr_valid,
	input wire core_pkg::instr_t instr,
	input wire logic lsu_busy,
	output logic busy,
	output logic [`CORE_REG_SEL_WIDTH-1:0] read_sel_1,
	output logic [`CORE_REG_SEL_WIDTH-1:0] read_sel_2,
	input wire logic [`CORE_DATA_WIDTH-1:0] read_data_1,
	input wire logic [`CORE_DATA_WIDTH-1:0] read_data_2,
	output logic go,
	output core_pkg::opcode_t opcode,
	output logic [`CORE_REG_SEL_WIDTH-1:0] rd,
	output logic [`CORE_DATA_WIDTH-1:0] operand_a,
	output logic [`CORE_DATA_WIDTH-1:0] operand_b,
	output logic [7:0] imm,
	output logic lsu_start,
	output core_pkg::opcode_t lsu_opcode,
	output logic [`CORE_REG_SEL_WIDTH-1:0] lsu_rd,
	output logic [`CORE_MEM_ADDR_WIDTH-1:0] lsu_addr,
	output logic [`CORE_DATA_WIDTH-1:0] lsu_wdata
);

	logic accept;
	logic is_mem;

	assign accept = instr_valid && !busy;
	assign is_mem = (instr.opcode == core_pkg::OP_LOAD) || (instr.opcode == core_pkg::OP_STORE);

	// Operand fetch straight from the instruction
	assign read_sel_1 = instr.rs1;
	assign read_sel_2 = instr.rs2;

	//////////////////////////////
	// ALU side, same cycle
	//////////////////////////////

	assign go = accept && !is_mem;
	assign opcode = instr.opcode;
	assign rd = instr.rd;
	assign operand_a = read_data_1;
	assign operand_b = read_data_2;
	assign imm = instr.imm;

	//////////////////////////////
	// Load/store hand-off
	//////////////////////////////

	// Start flag also bridges busy until lsu_busy rises
	always_ff @(posedge clk) begin
		if (reset) begin
			lsu_start <= 1'b0;
		end else begin
			lsu_start <= accept && is_mem;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_mem) begin
			lsu_opcode <= instr.opcode;
			lsu_rd <= instr.rd;
			lsu_addr <= read_data_1[`CORE_MEM_ADDR_WIDTH-1:0] + instr.imm;
			lsu_wdata <= read_data_2;
		end
	end

	assign busy = lsu_start || lsu_busy;

endmodule

`default_nettype wire

// ==== design/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module load_store_unit (
	input wire logic clk,
	input wire logic reset,
	input wire logic lsu_start,
	input wire core_pkg::opcode_t lsu_opcode,
	input wire logic [`CORE_REG_SEL_WIDTH-1:0] lsu_rd,
	input wire logic [`CORE_MEM_ADDR_WIDTH-1:0] lsu_addr,
	input wire logic [`CORE_DATA_WIDTH-1:0] lsu_wdata,
	output logic lsu_busy,
	output core_pkg::mem_req_t lsu_req,
	input wire logic lsu_grant,
	input wire logic lsu_rsp_valid,
	input wire logic [`CORE_DATA_WIDTH-1:0] rdata,
	output core_pkg::reg_write_t lsu_write
);

	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_REQ,
		LSU_WAIT
	} lsu_state_t;

	lsu_state_t state;

	logic store_q;
	logic [`CORE_REG_SEL_WIDTH-1:0] rd_q;
	logic [`CORE_MEM_ADDR_WIDTH-1:0] addr_q;
	logic [`CORE_DATA_WIDTH-1:0] wdata_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LSU_IDLE;
		end else begin
			case (state)
				LSU_IDLE: if (lsu_start) state <= LSU_REQ;
				// Stores are done at grant, loads wait for data
				LSU_REQ: if (lsu_grant) state <= store_q ? LSU_IDLE : LSU_WAIT;
				LSU_WAIT: if (lsu_rsp_valid) state <= LSU_IDLE;
				default: state <= LSU_IDLE;
			endcase
		end
	end

	// Command latched once, held through the grant wait
	always_ff @(posedge clk) begin
		if (state == LSU_IDLE && lsu_start) begin
			store_q <= (lsu_opcode == core_pkg::OP_STORE);
			rd_q <= lsu_rd;
			addr_q <= lsu_addr;
			wdata_q <= lsu_wdata;
		end
	end

	assign lsu_busy = (state != LSU_IDLE);

	assign lsu_req.valid = (state == LSU_REQ);
	assign lsu_req.write = store_q;
	assign lsu_req.addr = addr_q;
	assign lsu_req.wdata = wdata_q;

	// Loaded word goes to port 2 as it arrives
	assign lsu_write.en = (state == LSU_WAIT) && lsu_rsp_valid;
	assign lsu_write.sel = rd_q;
	assign lsu_write.data = rdata;

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input wire logic clk,
	input wire logic reset,
	input wire core_pkg::mem_req_t lsu_req,
	input wire core_pkg::mem_req_t host_req,
	output logic lsu_grant,
	output logic host_grant,
	output logic lsu_rsp_valid,
	output logic host_rsp_valid,
	output core_pkg::mem_req_t mem_req
);

	//////////////////////////////
	// Fixed priority grant
	//////////////////////////////

	// Load/store unit always wins a tie
	assign lsu_grant = lsu_req.valid;
	assign host_grant = host_req.valid && !lsu_req.valid;

	always_comb begin
		if (lsu_grant) begin
			mem_req = lsu_req;
		end else if (host_grant) begin
			mem_req = host_req;
		end else begin
			mem_req = '0;
		end
	end

	//////////////////////////////
	// Response routing
	//////////////////////////////

	// Read owner recorded at grant, data shows up next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			lsu_rsp_valid <= 1'b0;
			host_rsp_valid <= 1'b0;
		end else begin
			lsu_rsp_valid <= lsu_grant && !lsu_req.write;
			host_rsp_valid <= host_grant && !host_req.write;
		end
	end

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module data_memory (
	input wire logic clk,
	input wire core_pkg::mem_req_t mem_req,
	output logic [`CORE_DATA_WIDTH-1:0] rdata
);

	logic [`CORE_DATA_WIDTH-1:0] mem [`CORE_MEM_DEPTH];

	// Single port, read data registered
	always_ff @(posedge clk) begin
		if (mem_req.valid) begin
			if (mem_req.write) begin
				mem[mem_req.addr] <= mem_req.wdata;
			end else begin
				rdata <= mem[mem_req.addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic instr_valid,
	input wire core_pkg::instr_t instr,
	output logic busy,
	input wire core_pkg::mem_req_t host_req,
	output logic host_grant,
	output logic host_rsp_valid,
	output logic [`CORE_DATA_WIDTH-1:0] host_rdata
);

	// Register file reads
	logic [`CORE_REG_SEL_WIDTH-1:0] read_sel_1;
	logic [`CORE_REG_SEL_WIDTH-1:0] read_sel_2;
	logic [`CORE_DATA_WIDTH-1:0] read_data_1;
	logic [`CORE_DATA_WIDTH-1:0] read_data_2;

	// ALU path
	logic go;
	core_pkg::opcode_t opcode;
	logic [`CORE_REG_SEL_WIDTH-1:0] rd;
	logic [`CORE_DATA_WIDTH-1:0] operand_a;
	logic [`CORE_DATA_WIDTH-1:0] operand_b;
	logic [7:0] imm;
	core_pkg::reg_write_t alu_write;

	// Load/store path
	logic lsu_start;
	core_pkg::opcode_t lsu_opcode;
	logic [`CORE_REG_SEL_WIDTH-1:0] lsu_rd;
	logic [`CORE_MEM_ADDR_WIDTH-1:0] lsu_addr;
	logic [`CORE_DATA_WIDTH-1:0] lsu_wdata;
	logic lsu_busy;
	core_pkg::mem_req_t lsu_req;
	core_pkg::reg_write_t lsu_write;
	logic lsu_grant;
	logic lsu_rsp_valid;

	// Memory side
	core_pkg::mem_req_t mem_req;
	logic [`CORE_DATA_WIDTH-1:0] rdata;

	assign host_rdata = rdata;

	register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.read_sel_1(read_sel_1),
		.read_sel_2(read_sel_2),
		.read_data_1(read_data_1),
		.read_data_2(read_data_2),
		.port_1_write(alu_write),
		.port_2_write(lsu_write)
	);

	issue_unit u_issue_unit (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.lsu_busy(lsu_busy),
		.busy(busy),
		.read_sel_1(read_sel_1),
		.read_sel_2(read_sel_2),
		.read_data_1(read_data_1),
		.read_data_2(read_data_2),
		.go(go),
		.opcode(opcode),
		.rd(rd),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.imm(imm),
		.lsu_start(lsu_start),
		.lsu_opcode(lsu_opcode),
		.lsu_rd(lsu_rd),
		.lsu_addr(lsu_addr),
		.lsu_wdata(lsu_wdata)
	);

	alu_unit u_alu_unit (
		.go(go),
		.opcode(opcode),
		.rd(rd),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.imm(imm),
		.alu_write(alu_write)
	);

	load_store_unit u_load_store_unit (
		.clk(clk),
		.reset(reset),
		.lsu_start(lsu_start),
		.lsu_opcode(lsu_opcode),
		.lsu_rd(lsu_rd),
		.lsu_addr(lsu_addr),
		.lsu_wdata(lsu_wdata),
		.lsu_busy(lsu_busy),
		.lsu_req(lsu_req),
		.lsu_grant(lsu_grant),
		.lsu_rsp_valid(lsu_rsp_valid),
		.rdata(rdata),
		.lsu_write(lsu_write)
	);

	mem_arbiter u_mem_arbiter (
		.clk(clk),
		.reset(reset),
		.lsu_req(lsu_req),
		.host_req(host_req),
		.lsu_grant(lsu_grant),
		.host_grant(host_grant),
		.lsu_rsp_valid(lsu_rsp_valid),
		.host_rsp_valid(host_rsp_valid),
		.mem_req(mem_req)
	);

	data_memory u_data_memory (
		.clk(clk),
		.mem_req(mem_req),
		.rdata(rdata)
	);

endmodule

`default_nettype wire

// ==== test/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_checker (
	input wire logic clk,
	input wire logic reset,
	input wire core_pkg::reg_write_t port_2_write,
	input wire logic [`CORE_DATA_WIDTH-1:0] port_2_target,
	input wire logic lsu_grant,
	input wire logic host_grant,
	input wire core_pkg::mem_req_t host_req,
	input wire logic host_rsp_valid
);

	logic port_2_special;

	assign port_2_special = (port_2_write.sel == `CORE_SPECIAL_REG_A) ||
		(port_2_write.sel == `CORE_SPECIAL_REG_B);

	// Port 2 aimed at an ALU register must leave that register alone
	port_2_owner: assert property (@(posedge clk) disable iff (reset)
		(port_2_write.en && !port_2_special) |=> $stable(port_2_target))
		else $error("port 2 changed register %0d", port_2_write.sel);

	one_grant: assert property (@(posedge clk) disable iff (reset)
		!(lsu_grant && host_grant))
		else $error("load/store and host granted in the same cycle");

	//////////////////////////////
	// Host response pairing
	//////////////////////////////

	host_rsp_follows_read: assert property (@(posedge clk) disable iff (reset)
		(host_grant && !host_req.write) |=> host_rsp_valid)
		else $error("granted host read got no response");

	host_rsp_needs_read: assert property (@(posedge clk) disable iff (reset)
		host_rsp_valid |-> $past(host_grant && !host_req.write))
		else $error("host response without a granted host read");

endmodule

bind register_file core_checker u_port_checker (
	.clk(clk),
	.reset(reset),
	.port_2_write(port_2_write),
	.port_2_target(regs[port_2_write.sel]),
	.lsu_grant(1'b0),
	.host_grant(1'b0),
	.host_req('0),
	.host_rsp_valid(1'b0)
);

bind mem_arbiter core_checker u_grant_checker (
	.clk(clk),
	.reset(reset),
	.port_2_write('0),
	.port_2_target('0),
	.lsu_grant(lsu_grant),
	.host_grant(host_grant),
	.host_req(host_req),
	.host_rsp_valid(host_rsp_valid)
);

`default_nettype wire

// ==== test/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_tb;

	logic clk;
	logic reset;
	logic instr_valid;
	core_pkg::instr_t instr;
	logic busy;
	core_pkg::mem_req_t host_req;
	logic host_grant;
	logic host_rsp_valid;
	logic [`CORE_DATA_WIDTH-1:0] host_rdata;

	// Reference state
	logic [`CORE_DATA_WIDTH-1:0] reg_model [`CORE_REG_COUNT];
	logic [`CORE_DATA_WIDTH-1:0] mem_model [`CORE_MEM_DEPTH];
	logic [`CORE_DATA_WIDTH-1:0] expected_q [$];

	int ops_issued;
	int cycle_count;

	core_top UUT (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.busy(busy),
		.host_req(host_req),
		.host_grant(host_grant),
		.host_rsp_valid(host_rsp_valid),
		.host_rdata(host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("STATUS: FAIL");
		$fatal(1, "%s", what);
	endtask

	task automatic check_equal(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected) begin
			$display("error: time %0t %s got %h expected %h", $time, name, got, expected);
			fail_run("value mismatch");
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic is_special(input logic [3:0] sel);
		return (sel == `CORE_SPECIAL_REG_A) || (sel == `CORE_SPECIAL_REG_B);
	endfunction

	function automatic logic [15:0] alu_ref(input core_pkg::opcode_t op,
		input logic [15:0] a, input logic [15:0] b, input logic [7:0] imm);
		case (op)
			core_pkg::OP_ADD: return a + b;
			core_pkg::OP_SUB: return a - b;
			core_pkg::OP_AND: return a & b;
			core_pkg::OP_XOR: return a ^ b;
			core_pkg::OP_MOVI: return {8'h00, imm};
			default: return 16'h0000;
		endcase
	endfunction

	// Writes aimed at the other port's registers are dropped
	function automatic void apply_instr(input core_pkg::instr_t i);
		logic [7:0] addr;
		addr = reg_model[i.rs1][7:0] + i.imm;
		case (i.opcode)
			core_pkg::OP_LOAD: begin
				if (is_special(i.rd)) reg_model[i.rd] = mem_model[addr];
			end
			core_pkg::OP_STORE: mem_model[addr] = reg_model[i.rs2];
			default: begin
				if (!is_special(i.rd)) begin
					reg_model[i.rd] = alu_ref(i.opcode, reg_model[i.rs1],
						reg_model[i.rs2], i.imm);
				end
			end
		endcase
	endfunction

	function automatic core_pkg::instr_t make_instr(input core_pkg::opcode_t op,
		input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2,
		input logic [7:0] imm);
		core_pkg::instr_t i;
		i.opcode = op;
		i.rd = rd;
		i.rs1 = rs1;
		i.rs2 = rs2;
		i.imm = imm;
		return i;
	endfunction

	// Random register owned by the ALU port
	function automatic logic [3:0] general_reg();
		int r;
		r = $urandom_range(0, 13);
		if (r >= 12) r = r + 2;
		return 4'(r);
	endfunction

	function automatic core_pkg::opcode_t random_alu_op();
		return core_pkg::opcode_t'(3'($urandom_range(0, 3)));
	endfunction

	//////////////////////////////
	// Drivers
	//////////////////////////////

	// Returns once the core is idle again
	task automatic issue(input core_pkg::instr_t i);
		logic mem_op;
		mem_op = (i.opcode == core_pkg::OP_LOAD) || (i.opcode == core_pkg::OP_STORE);
		ops_issued++;
		apply_instr(i);
		instr = i;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		// Loads and stores hold busy from the next cycle, ALU work never does
		check_equal("busy", {15'd0, busy}, {15'd0, mem_op});
		while (busy) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Request held until granted, grant sampled mid-cycle
	task automatic host_access(input logic write, input logic [7:0] addr,
		input logic [15:0] data);
		ops_issued++;
		host_req.valid = 1'b1;
		host_req.write = write;
		host_req.addr = addr;
		host_req.wdata = data;
		@(negedge clk);
		while (!host_grant) @(negedge clk);
		if (write) mem_model[addr] = data;
		else expected_q.push_back(mem_model[addr]);
		@(posedge clk);
		#1;
		host_req = '0;
	endtask

	// Address base is r0, imm chosen to hit the target word
	task automatic load_word(input logic [3:0] rd, input logic [7:0] target);
		issue(make_instr(core_pkg::OP_LOAD, rd, 4'd0, 4'd0, target - reg_model[0][7:0]));
	endtask

	task automatic store_word(input logic [3:0] rs, input logic [7:0] target);
		issue(make_instr(core_pkg::OP_STORE, 4'd0, 4'd0, rs, target - reg_model[0][7:0]));
	endtask

	task automatic dump_regs(input logic [7:0] base);
		for (int r = 0; r < `CORE_REG_COUNT; r++) begin
			store_word(4'(r), base + 8'(r));
			host_access(1'b0, base + 8'(r), 16'h0000);
		end
	endtask

	//////////////////////////////
	// Compare and timeout
	//////////////////////////////

	always @(negedge clk) begin
		if (!reset && host_rsp_valid) begin
			if (expected_q.size() == 0) fail_run("host response with no read outstanding");
			else check_equal("host_rdata", host_rdata, expected_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > 20 * ops_issued + 100) begin
			fail_run("timeout, the core stopped responding");
		end
	end

	initial begin
		void'($urandom(32'hca66_b55e));
		ops_issued = 0;
		cycle_count = 0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		host_req = '0;
		for (int k = 0; k < `CORE_REG_COUNT; k++) reg_model[k] = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// Quiet after reset, registers all zero
		repeat (2) begin
			@(negedge clk);
			check_equal("busy", {15'd0, busy}, 16'h0000);
			check_equal("host_grant", {15'd0, host_grant}, 16'h0000);
			check_equal("host_rsp_valid", {15'd0, host_rsp_valid}, 16'h0000);
		end
		@(posedge clk);
		#1;
		dump_regs(8'hc0);

		// Immediates then random ALU traffic
		for (int r = 0; r < `CORE_REG_COUNT; r++) begin
			if (!is_special(4'(r))) begin
				issue(make_instr(core_pkg::OP_MOVI, 4'(r), 4'd0, 4'd0, 8'($urandom)));
			end
		end
		repeat (40) begin
			issue(make_instr(random_alu_op(), general_reg(), 4'($urandom), 4'($urandom),
				8'($urandom)));
		end
		dump_regs(8'hc0);

		// Host-written words through the special registers
		for (int k = 0; k < 16; k++) host_access(1'b1, 8'h10 + 8'(k), 16'($urandom));
		for (int k = 0; k < 8; k++) begin
			load_word((k % 2 == 1) ? 4'd13 : 4'd12, 8'h10 + 8'(k * 2));
			store_word((k % 2 == 1) ? 4'd13 : 4'd12, 8'ha0 + 8'(k));
			host_access(1'b0, 8'ha0 + 8'(k), 16'h0000);
		end

		// Wrong-port writes must vanish
		issue(make_instr(core_pkg::OP_MOVI, 4'd12, 4'd0, 4'd0, 8'($urandom)));
		issue(make_instr(core_pkg::OP_MOVI, 4'd13, 4'd0, 4'd0, 8'($urandom)));
		for (int k = 0; k < 6; k++) begin
			issue(make_instr(random_alu_op(), (k % 2 == 1) ? 4'd13 : 4'd12, 4'($urandom),
				4'($urandom), 8'($urandom)));
			load_word(general_reg(), 8'h10 + 8'(k));
		end
		dump_regs(8'hc0);

		// Host traffic racing loads and stores
		fork
			begin
				for (int k = 0; k < 12; k++) begin
					load_word((k % 2 == 1) ? 4'd12 : 4'd13, 8'h10 + 8'(k));
					issue(make_instr(random_alu_op(), general_reg(), 4'($urandom),
						4'($urandom), 8'($urandom)));
					store_word(4'($urandom), 8'h80 + 8'(k));
				end
			end
			begin
				for (int k = 0; k < 16; k++) begin
					host_access(1'b0, 8'h10 + 8'(k), 16'h0000);
					host_access(1'b1, 8'h40 + 8'(k), 16'($urandom));
				end
			end
		join
		for (int k = 0; k < 12; k++) host_access(1'b0, 8'h80 + 8'(k), 16'h0000);
		for (int k = 0; k < 16; k++) host_access(1'b0, 8'h40 + 8'(k), 16'h0000);
		dump_regs(8'hc0);

		repeat (3) @(posedge clk);
		if (expected_q.size() != 0) begin
			fail_run("host read response missing at end of run");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
design/core_pkg.sv
design/register_file.sv
design/alu_unit.sv
design/issue_unit.sv
design/load_store_unit.sv
design/mem_arbiter.sv
design/data_memory.sv
design/core_top.sv
test/core_checker.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the run
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module core_tb -Mdir obj_dir \
	&& ./obj_dir/Vcore_tb \
	|| exit 1
